// ==== hdl/hygro_pkg.sv ====
/*
 * HDC1080 hygrometer protocol definitions
 * sequencer states, the 16-bit register word with its byte view,
 * sensor register pointers and bus framing constants
 */
package hygro_pkg;

   // sequencer states, byte states are each followed by their ack slot
   typedef enum logic [4:0] {
      ST_IDLE,
      ST_START,
      ST_SLAVE_ADDR_WR,
      ST_ACK1,
      ST_STOP,
      ST_HOLD,
      // configuration write
      ST_CONFIG_PTR,
      ST_ACK2,
      ST_CONFIG_HI,
      ST_ACK3,
      ST_CONFIG_LO,
      ST_ACK4,
      // measurement read
      ST_READ_PTR,
      ST_ACK5,
      ST_STOP_READING,
      ST_HOLD_READING,
      ST_START_READING,
      ST_SLAVE_ADDR_RD,
      ST_ACK6,
      ST_TEMP_HI,
      ST_ACK7,
      ST_TEMP_LO,
      ST_ACK8,
      ST_HUMID_HI,
      ST_ACK9,
      ST_HUMID_LO,
      ST_NO_ACK
   } hygro_state_t;

   // sensor register, seen whole or as two bytes in bus order
   typedef union packed {
      logic [15:0]     word;
      logic [0:1][7:0] bytes;   // bytes[0] is the msbyte, sent first
   } reg_word_t;

   // register pointers inside the sensor
   localparam logic [7:0] CONFIG_REG_PTR = 8'h02;
   localparam logic [7:0] TEMP_REG_PTR   = 8'h00;

   // data bits ahead of every ack slot
   localparam int BITS_PER_BYTE  = 8;
   // fast clocks per scl period
   localparam int PHASES_PER_BIT = 4;

endpackage

// ==== hdl/i2c_bit_phase.sv ====
/*
 * I2C bit phase source
 * divides each SCL period into four phases of the fast clock and gives
 * the SCL level, an update strobe a quarter period after SCL falls and
 * a sample strobe while SCL is high
 */
`timescale 1ns/1ps

module i2c_bit_phase (
   input  logic s_i2c_clk_4x,
   input  logic i_reset,
   output logic o_scl_level,
   output logic o_update_ce,
   output logic o_sample_ce
);

   localparam int PH_W = $clog2(hygro_pkg::PHASES_PER_BIT);
   // last phase of a period
   localparam logic [PH_W-1:0] PH_LAST = PH_W'(hygro_pkg::PHASES_PER_BIT - 1);
   // first phase with scl high, also the sample point
   localparam logic [PH_W-1:0] PH_HIGH = PH_W'(hygro_pkg::PHASES_PER_BIT / 2);

   logic [PH_W-1:0] phase;
   logic [PH_W-1:0] phase_nx;

   // free running phase, wraps once per scl period
   assign phase_nx = (phase == PH_LAST) ? '0 : phase + 1'b1;

   // strobes decoded from the next phase so they line up with the counter
   always_ff @(posedge s_i2c_clk_4x) begin
      if (i_reset) begin
         phase       <= '0;
         o_scl_level <= 1'b0;
         o_update_ce <= 1'b1;
         o_sample_ce <= 1'b0;
      end else begin
         phase       <= phase_nx;
         // scl low for the first half of the period
         o_scl_level <= (phase_nx >= PH_HIGH);
         // phase 0, scl has just fallen
         o_update_ce <= (phase_nx == '0);
         // phase 2, scl has just risen
         o_sample_ce <= (phase_nx == PH_HIGH);
      end
   end

endmodule

// ==== hdl/hygro_sequencer.sv ====
/*
 * HDC1080 transaction sequencer
 * walks the START, address, pointer, data and STOP sequence of a config
 * write or a measurement read, one state step per SCL period, and
 * drives SCL and SDA; tells the capture unit when a read bit is on SDA
 */
`timescale 1ns/1ps

module hygro_sequencer #(
   parameter logic [6:0] I2C_ADDR         = 7'h40,
   parameter int         HOLD_BIT_PERIODS = 2000
) (
   input  logic        s_i2c_clk_4x,
   input  logic        i_reset,
   input  logic        i_update_ce,
   input  logic        i_sample_ce,
   input  logic        i_scl_level,
   input  logic        i_wr,
   input  logic        i_rd,
   input  logic [15:0] i_config,
   output logic        o_scl,
   output logic        o_sda_o,
   output logic        o_sda_t,
   output logic        o_rx_bit,
   output logic        o_rx_humid,
   output logic        o_rx_last
);

   localparam int CNT_W = $clog2(hygro_pkg::BITS_PER_BYTE);
   localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(hygro_pkg::BITS_PER_BYTE - 1);
   localparam int HOLD_W = $clog2(HOLD_BIT_PERIODS + 1);
   localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(HOLD_BIT_PERIODS - 1);
   // address byte with the r/w bit appended
   localparam logic [7:0] ADDR_WR = {I2C_ADDR, 1'b0};
   localparam logic [7:0] ADDR_RD = {I2C_ADDR, 1'b1};

   hygro_pkg::hygro_state_t state;
   hygro_pkg::hygro_state_t byte_next;
   hygro_pkg::reg_word_t    config_q;
   logic [CNT_W-1:0]        bit_cnt;
   logic [HOLD_W-1:0]       hold_cnt;
   logic [7:0]              tx_byte;
   logic                    tx_state;
   logic                    rx_state;
   logic                    last_bit;

   assign last_bit = (bit_cnt == LAST_BIT);

   // byte states: what goes out, and which ack slot follows
   always_comb begin
      tx_byte   = 8'h00;
      byte_next = state;
      tx_state  = 1'b0;
      rx_state  = 1'b0;
      case (state)
         hygro_pkg::ST_SLAVE_ADDR_WR: begin
            tx_byte   = ADDR_WR;
            byte_next = hygro_pkg::ST_ACK1;
            tx_state  = 1'b1;
         end
         hygro_pkg::ST_CONFIG_PTR: begin
            tx_byte   = hygro_pkg::CONFIG_REG_PTR;
            byte_next = hygro_pkg::ST_ACK2;
            tx_state  = 1'b1;
         end
         hygro_pkg::ST_CONFIG_HI: begin
            tx_byte   = config_q.bytes[0];
            byte_next = hygro_pkg::ST_ACK3;
            tx_state  = 1'b1;
         end
         hygro_pkg::ST_CONFIG_LO: begin
            tx_byte   = config_q.bytes[1];
            byte_next = hygro_pkg::ST_ACK4;
            tx_state  = 1'b1;
         end
         hygro_pkg::ST_READ_PTR: begin
            tx_byte   = hygro_pkg::TEMP_REG_PTR;
            byte_next = hygro_pkg::ST_ACK5;
            tx_state  = 1'b1;
         end
         hygro_pkg::ST_SLAVE_ADDR_RD: begin
            tx_byte   = ADDR_RD;
            byte_next = hygro_pkg::ST_ACK6;
            tx_state  = 1'b1;
         end
         hygro_pkg::ST_TEMP_HI: begin
            byte_next = hygro_pkg::ST_ACK7;
            rx_state  = 1'b1;
         end
         hygro_pkg::ST_TEMP_LO: begin
            byte_next = hygro_pkg::ST_ACK8;
            rx_state  = 1'b1;
         end
         hygro_pkg::ST_HUMID_HI: begin
            byte_next = hygro_pkg::ST_ACK9;
            rx_state  = 1'b1;
         end
         hygro_pkg::ST_HUMID_LO: begin
            byte_next = hygro_pkg::ST_NO_ACK;
            rx_state  = 1'b1;
         end
         default: begin
            byte_next = state;
         end
      endcase
   end

   // state, bit and hold counters step once per scl period
   always_ff @(posedge s_i2c_clk_4x) begin
      if (i_reset) begin
         state    <= hygro_pkg::ST_IDLE;
         bit_cnt  <= '0;
         hold_cnt <= '0;
      end else if (i_update_ce) begin
         if (tx_state || rx_state) begin
            // msb first, ack slot after the last bit
            if (last_bit) begin
               bit_cnt <= '0;
               state   <= byte_next;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end else begin
            case (state)
               hygro_pkg::ST_IDLE:
                  if (i_wr || i_rd) state <= hygro_pkg::ST_START;
               hygro_pkg::ST_START:
                  state <= hygro_pkg::ST_SLAVE_ADDR_WR;
               // write wins when both strobes are up
               hygro_pkg::ST_ACK1:
                  state <= i_wr ? hygro_pkg::ST_CONFIG_PTR : hygro_pkg::ST_READ_PTR;
               hygro_pkg::ST_ACK2:
                  state <= hygro_pkg::ST_CONFIG_HI;
               hygro_pkg::ST_ACK3:
                  state <= hygro_pkg::ST_CONFIG_LO;
               hygro_pkg::ST_ACK4:
                  state <= hygro_pkg::ST_STOP;
               hygro_pkg::ST_STOP:
                  state <= hygro_pkg::ST_HOLD;
               // wait for the host to drop both strobes
               hygro_pkg::ST_HOLD:
                  if (!i_wr && !i_rd) state <= hygro_pkg::ST_IDLE;
               hygro_pkg::ST_ACK5: begin
                  hold_cnt <= '0;
                  state    <= hygro_pkg::ST_STOP_READING;
               end
               hygro_pkg::ST_STOP_READING:
                  state <= hygro_pkg::ST_HOLD_READING;
               // sensor converts while the bus sits idle
               hygro_pkg::ST_HOLD_READING:
                  if (hold_cnt == HOLD_LAST) begin
                     state <= hygro_pkg::ST_START_READING;
                  end else begin
                     hold_cnt <= hold_cnt + 1'b1;
                  end
               hygro_pkg::ST_START_READING:
                  state <= hygro_pkg::ST_SLAVE_ADDR_RD;
               hygro_pkg::ST_ACK6:
                  state <= hygro_pkg::ST_TEMP_HI;
               hygro_pkg::ST_ACK7:
                  state <= hygro_pkg::ST_TEMP_LO;
               hygro_pkg::ST_ACK8:
                  state <= hygro_pkg::ST_HUMID_HI;
               hygro_pkg::ST_ACK9:
                  state <= hygro_pkg::ST_HUMID_LO;
               hygro_pkg::ST_NO_ACK:
                  state <= hygro_pkg::ST_STOP;
               default:
                  state <= hygro_pkg::ST_IDLE;
            endcase
         end
      end
   end

   // config word taken in the first ack slot of a write
   always_ff @(posedge s_i2c_clk_4x) begin
      if (i_update_ce && (state == hygro_pkg::ST_ACK1) && i_wr) begin
         config_q.word <= i_config;
      end
   end

   // bus drive, a state spans scl phases 1, 2, 3 and 0
   always_comb begin
      o_scl   = i_scl_level;
      o_sda_o = 1'b0;
      o_sda_t = 1'b1;
      case (state)
         hygro_pkg::ST_IDLE, hygro_pkg::ST_HOLD, hygro_pkg::ST_HOLD_READING: begin
            o_scl   = 1'b1;
            o_sda_o = 1'b1;
            o_sda_t = 1'b0;
         end
         // sda falls with scl high, scl drops in the last phase
         hygro_pkg::ST_START, hygro_pkg::ST_START_READING: begin
            o_scl   = ~i_update_ce;
            o_sda_t = 1'b0;
         end
         // sda low under a low scl, then scl rises and stays up
         hygro_pkg::ST_STOP, hygro_pkg::ST_STOP_READING: begin
            o_scl   = i_scl_level | i_update_ce;
            o_sda_t = 1'b0;
         end
         // master ack after temp and first humid byte
         hygro_pkg::ST_ACK7, hygro_pkg::ST_ACK8, hygro_pkg::ST_ACK9: begin
            o_sda_t = 1'b0;
         end
         // nack ends the read burst
         hygro_pkg::ST_NO_ACK: begin
            o_sda_o = 1'b1;
            o_sda_t = 1'b0;
         end
         default: begin
            if (tx_state) begin
               o_sda_o = tx_byte[LAST_BIT - bit_cnt];
               o_sda_t = 1'b0;
            end
            // slave ack slots and read bits stay released
         end
      endcase
   end

   // read bit strobe for the capture unit, mid scl high
   assign o_rx_bit   = rx_state & i_sample_ce;
   assign o_rx_humid = (state == hygro_pkg::ST_HUMID_HI) || (state == hygro_pkg::ST_HUMID_LO);
   assign o_rx_last  = (state == hygro_pkg::ST_HUMID_LO) && last_bit;

endmodule

// ==== hdl/hygro_data_capture.sv ====
/*
 * HDC1080 measurement capture
 * shifts read bits MSB first into the temperature or humidity word
 * and pulses valid once the last humidity bit is in
 */
`timescale 1ns/1ps

module hygro_data_capture (
   input  logic        s_i2c_clk_4x,
   input  logic        i_reset,
   input  logic        i_sda_in,
   input  logic        i_rx_bit,
   input  logic        i_rx_humid,
   input  logic        i_rx_last,
   output logic [15:0] o_temp,
   output logic [15:0] o_humid,
   output logic        o_valid
);

   hygro_pkg::reg_word_t temp_q;
   hygro_pkg::reg_word_t humid_q;

   // one bit in at the low byte, msb of low byte carries into high byte
   function automatic hygro_pkg::reg_word_t shift_in(input hygro_pkg::reg_word_t w,
                                                     input logic b);
      hygro_pkg::reg_word_t r;
      r.bytes[0] = {w.bytes[0][6:0], w.bytes[1][7]};
      r.bytes[1] = {w.bytes[1][6:0], b};
      return r;
   endfunction

   always_ff @(posedge s_i2c_clk_4x) begin
      if (i_reset) begin
         temp_q.word  <= 16'h0000;
         humid_q.word <= 16'h0000;
         o_valid      <= 1'b0;
      end else begin
         // valid lands one clock after the final sample
         o_valid <= i_rx_bit & i_rx_last;
         if (i_rx_bit) begin
            if (i_rx_humid) begin
               humid_q <= shift_in(humid_q, i_sda_in);
            end else begin
               temp_q <= shift_in(temp_q, i_sda_in);
            end
         end
      end
   end

   assign o_temp  = temp_q.word;
   assign o_humid = humid_q.word;

endmodule

// ==== hdl/pmod_hygro_i2c.sv ====
/*
 * PMOD HYGRO I2C master, single sensor on the bus
 * writes the HDC1080 configuration register on a write strobe and reads
 * temperature and humidity on a read strobe, all in the 4x SCL clock
 */
`timescale 1ns/1ps

module pmod_hygro_i2c #(
   parameter logic [6:0] I2C_ADDR         = 7'h40,
   parameter int         HOLD_BIT_PERIODS = 2000
) (
   input  logic        s_i2c_clk_4x,
   input  logic        i_reset,
   input  logic        i_wr,
   input  logic        i_rd,
   input  logic [15:0] i_config,
   input  logic        i_sda,
   output logic        o_scl,
   output logic        o_sda_o,
   output logic        o_sda_t,
   output logic [15:0] o_temp,
   output logic [15:0] o_humid,
   output logic        o_valid
);

   // phase source to sequencer
   logic scl_level;
   logic update_ce;
   logic sample_ce;
   // sequencer to capture
   logic rx_bit;
   logic rx_humid;
   logic rx_last;

   i2c_bit_phase u_bit_phase (
      .s_i2c_clk_4x (s_i2c_clk_4x),
      .i_reset      (i_reset),
      .o_scl_level  (scl_level),
      .o_update_ce  (update_ce),
      .o_sample_ce  (sample_ce)
   );

   hygro_sequencer #(
      .I2C_ADDR         (I2C_ADDR),
      .HOLD_BIT_PERIODS (HOLD_BIT_PERIODS)
   ) u_sequencer (
      .s_i2c_clk_4x (s_i2c_clk_4x),
      .i_reset      (i_reset),
      .i_update_ce  (update_ce),
      .i_sample_ce  (sample_ce),
      .i_scl_level  (scl_level),
      .i_wr         (i_wr),
      .i_rd         (i_rd),
      .i_config     (i_config),
      .o_scl        (o_scl),
      .o_sda_o      (o_sda_o),
      .o_sda_t      (o_sda_t),
      .o_rx_bit     (rx_bit),
      .o_rx_humid   (rx_humid),
      .o_rx_last    (rx_last)
   );

   hygro_data_capture u_capture (
      .s_i2c_clk_4x (s_i2c_clk_4x),
      .i_reset      (i_reset),
      .i_sda_in     (i_sda),
      .i_rx_bit     (rx_bit),
      .i_rx_humid   (rx_humid),
      .i_rx_last    (rx_last),
      .o_temp       (o_temp),
      .o_humid      (o_humid),
      .o_valid      (o_valid)
   );

endmodule

// ==== sim/hdc1080_model.sv ====
/*
 * HDC1080 behavioral bus model
 * oversamples SCL and SDA, logs START, STOP, written bytes and the
 * master's ack levels, and answers a read with four preset bytes
 */
`timescale 1ns/1ps

module hdc1080_model (
   input  logic        i_clk,
   input  logic        i_scl,
   input  logic        i_sda,
   input  logic [31:0] i_rd_data,
   output logic        o_sda_pull
);

   // event kind sits in the upper two bits of a log entry
   localparam logic [1:0] EV_START = 2'd0;
   localparam logic [1:0] EV_STOP  = 2'd1;
   localparam logic [1:0] EV_BYTE  = 2'd2;
   localparam logic [1:0] EV_ACK   = 2'd3;

   logic [9:0] log_q[$];
   time        stop_time = 0;
   time        idle_gap  = 0;
   logic       scl_r     = 1'b1;
   logic       sda_r     = 1'b1;
   logic [7:0] shreg     = 8'h00;
   int         bit_cnt   = 0;
   int         rd_idx    = 0;
   // first byte after START carries the r/w bit
   logic       first     = 1'b0;
   logic       rd_req    = 1'b0;
   // sensor owns sda for data bits
   logic       rd_mode   = 1'b0;

   initial o_sda_pull = 1'b0;

   task clear_log();
      log_q.delete();
   endtask

   // sampled mid cycle, away from the DUT clock edge
   always @(negedge i_clk) begin
      if (i_scl && scl_r && sda_r && !i_sda) begin
         log_q.push_back({EV_START, 8'h00});
         idle_gap = $time - stop_time;
         bit_cnt  = 0;
         rd_idx   = 0;
         first    = 1'b1;
         rd_req   = 1'b0;
         rd_mode  = 1'b0;
      end else if (i_scl && scl_r && !sda_r && i_sda) begin
         log_q.push_back({EV_STOP, 8'h00});
         stop_time = $time;
         bit_cnt   = 0;
         rd_mode   = 1'b0;
      end else if (i_scl && !scl_r) begin
         if (bit_cnt == 8) begin
            // ack slot, a nack from the master ends the burst
            if (rd_mode) begin
               log_q.push_back({EV_ACK, 7'd0, i_sda});
               rd_idx++;
               rd_mode = !i_sda;
            end else begin
               rd_mode = rd_req;
            end
            bit_cnt = 0;
         end else begin
            shreg = {shreg[6:0], i_sda};
            bit_cnt++;
            if (bit_cnt == 8 && !rd_mode) begin
               log_q.push_back({EV_BYTE, shreg});
               rd_req = first & shreg[0];
               first  = 1'b0;
            end
         end
      end else if (!i_scl && scl_r) begin
         // sda moves only while scl is low
         if (bit_cnt == 8 && !rd_mode) begin
            o_sda_pull = 1'b1;
         end else if (rd_mode && bit_cnt < 8 && rd_idx < 4) begin
            o_sda_pull = !i_rd_data[31 - 8 * rd_idx - bit_cnt];
         end else begin
            o_sda_pull = 1'b0;
         end
      end
      scl_r = i_scl;
      sda_r = i_sda;
   end

endmodule

// ==== sim/tb_pmod_hygro.sv ====
/*
 * Testbench for the PMOD HYGRO I2C master
 * directed config writes and measurement reads against a behavioral
 * HDC1080 on a resolved SDA line, checks bus traffic and results
 */
`timescale 1ns/1ps

module tb_pmod_hygro;

   localparam int CLK_PERIOD       = 100;
   localparam int HOLD_BIT_PERIODS = 8;
   // both lines high this long means the transaction is over
   localparam int IDLE_CLOCKS      = 12;
   // a read is about 90 periods of 4 clocks and five of them fit here many times
   localparam int TIMEOUT_CYCLES   = 40000;
   localparam logic [1:0] EV_START = 2'd0;
   localparam logic [1:0] EV_STOP  = 2'd1;
   localparam logic [1:0] EV_BYTE  = 2'd2;
   localparam logic [1:0] EV_ACK   = 2'd3;

   logic        clk = 1'b0;
   logic        reset;
   logic        wr;
   logic        rd;
   logic [15:0] cfg;
   logic        scl;
   logic        sda;
   logic        sda_o;
   logic        sda_t;
   logic        sda_pull;
   logic [15:0] temp;
   logic [15:0] humid;
   logic        valid;
   logic [31:0] sensor_data;
   logic [9:0]  exp_q[$];
   logic [15:0] exp_temp;
   logic [15:0] exp_humid;
   integer      seed;
   int          err_cnt   = 0;
   int          test_cnt  = 0;
   int          valid_cnt = 0;
   int          cycle_cnt = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   // open drain bus where the sensor wins when it pulls low
   assign sda = sda_pull ? 1'b0 : (sda_t ? 1'b1 : sda_o);

   pmod_hygro_i2c #(
      .I2C_ADDR         (7'h40),
      .HOLD_BIT_PERIODS (HOLD_BIT_PERIODS)
   ) uut (
      .s_i2c_clk_4x (clk),
      .i_reset      (reset),
      .i_wr         (wr),
      .i_rd         (rd),
      .i_config     (cfg),
      .i_sda        (sda),
      .o_scl        (scl),
      .o_sda_o      (sda_o),
      .o_sda_t      (sda_t),
      .o_temp       (temp),
      .o_humid      (humid),
      .o_valid      (valid)
   );

   hdc1080_model model (
      .i_clk      (clk),
      .i_scl      (scl),
      .i_sda      (sda),
      .i_rd_data  (sensor_data),
      .o_sda_pull (sda_pull)
   );

   always @(negedge clk) begin
      if (valid === 1'b1) begin
         valid_cnt++;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, a transaction never finished", cycle_cnt);
         $display("Finished with errors");
         $finish;
      end
   end

   task automatic flag_mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      err_cnt++;
      $display("Fail %0d ns: %s is %h, expected %h", $time, what, got, exp);
   endtask

   task automatic expect_event(input logic [1:0] kind, input logic [7:0] data);
      exp_q.push_back({kind, data});
   endtask

   task automatic compare_log(input string what);
      if (model.log_q.size() != exp_q.size()) begin
         flag_mismatch({what, " bus event count"}, model.log_q.size(), exp_q.size());
      end else begin
         foreach (exp_q[i]) begin
            if (model.log_q[i] !== exp_q[i]) begin
               flag_mismatch({what, " bus event"}, model.log_q[i], exp_q[i]);
            end
         end
      end
   endtask

   task automatic wait_bus_busy();
      @(negedge clk);
      while (scl === 1'b1 && sda === 1'b1) begin
         @(negedge clk);
      end
   endtask

   task automatic wait_bus_idle();
      int n;
      n = 0;
      while (n < IDLE_CLOCKS) begin
         @(negedge clk);
         n = (scl === 1'b1 && sda === 1'b1) ? n + 1 : 0;
      end
   endtask

   // lets the sequencer fall back from hold to idle
   task automatic settle();
      repeat (2 * 4) @(posedge clk);
   endtask

   task automatic check_hold();
      if (temp !== exp_temp) begin
         flag_mismatch("o_temp between reads", temp, exp_temp);
      end
      if (humid !== exp_humid) begin
         flag_mismatch("o_humid between reads", humid, exp_humid);
      end
   endtask

   task automatic check_reset();
      test_cnt++;
      if (scl !== 1'b1) begin
         flag_mismatch("o_scl after reset", scl, 1);
      end
      if (sda_o !== 1'b1) begin
         flag_mismatch("o_sda_o after reset", sda_o, 1);
      end
      if (sda_t !== 1'b0) begin
         flag_mismatch("o_sda_t after reset", sda_t, 0);
      end
      if (valid !== 1'b0) begin
         flag_mismatch("o_valid after reset", valid, 0);
      end
      check_hold();
   endtask

   // config write with optional i_rd and strobes held past STOP
   task automatic run_write(input logic [15:0] word, input logic with_rd, input int dwell);
      test_cnt++;
      model.clear_log();
      valid_cnt = 0;
      @(posedge clk);
      cfg <= word;
      wr  <= 1'b1;
      rd  <= with_rd;
      wait_bus_busy();
      wait_bus_idle();
      repeat (dwell) @(negedge clk);
      @(posedge clk);
      wr <= 1'b0;
      rd <= 1'b0;
      exp_q.delete();
      expect_event(EV_START, 8'h00);
      expect_event(EV_BYTE, 8'h80);
      expect_event(EV_BYTE, 8'h02);
      expect_event(EV_BYTE, word[15:8]);
      expect_event(EV_BYTE, word[7:0]);
      expect_event(EV_STOP, 8'h00);
      compare_log("write");
      if (valid_cnt != 0) begin
         flag_mismatch("o_valid pulses on write", valid_cnt, 0);
      end
      check_hold();
      settle();
   endtask

   // pointer write, hold, then four bytes back from the sensor
   task automatic run_read(input logic [31:0] data);
      test_cnt++;
      check_hold();
      model.clear_log();
      valid_cnt = 0;
      @(posedge clk);
      sensor_data <= data;
      rd          <= 1'b1;
      @(negedge clk);
      while (valid !== 1'b1) begin
         @(negedge clk);
      end
      if (temp !== data[31:16]) begin
         flag_mismatch("o_temp", temp, data[31:16]);
      end
      if (humid !== data[15:0]) begin
         flag_mismatch("o_humid", humid, data[15:0]);
      end
      wait_bus_idle();
      @(posedge clk);
      rd <= 1'b0;
      exp_temp  = data[31:16];
      exp_humid = data[15:0];
      exp_q.delete();
      expect_event(EV_START, 8'h00);
      expect_event(EV_BYTE, 8'h80);
      expect_event(EV_BYTE, 8'h00);
      expect_event(EV_STOP, 8'h00);
      expect_event(EV_START, 8'h00);
      expect_event(EV_BYTE, 8'h81);
      expect_event(EV_ACK, 8'h00);
      expect_event(EV_ACK, 8'h00);
      expect_event(EV_ACK, 8'h00);
      expect_event(EV_ACK, 8'h01);
      expect_event(EV_STOP, 8'h00);
      compare_log("read");
      if (model.idle_gap < HOLD_BIT_PERIODS * 4 * CLK_PERIOD) begin
         err_cnt++;
         $display("Fail %0d ns: bus idle only %0d ns before the read START, %0d ns expected",
                  $time, model.idle_gap, HOLD_BIT_PERIODS * 4 * CLK_PERIOD);
      end
      if (valid_cnt != 1) begin
         flag_mismatch("o_valid pulses on read", valid_cnt, 1);
      end
      settle();
   endtask

   initial begin
      seed        = 32'h93be_c1f5;
      reset       = 1'b1;
      wr          = 1'b0;
      rd          = 1'b0;
      cfg         = 16'h0000;
      sensor_data = 32'h0;
      exp_temp    = 16'h0000;
      exp_humid   = 16'h0000;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_reset();
      run_write(16'h1a5c, 1'b0, 0);
      run_read(32'h6c3e_8a17);
      repeat (3) run_read($random(seed));
      // write wins over read and no restart while strobes stay up
      run_write(16'h9000, 1'b1, 10 * 4);
      run_read($random(seed));
      $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== build.f ====
hdl/hygro_pkg.sv
hdl/i2c_bit_phase.sv
hdl/hygro_sequencer.sv
hdl/hygro_data_capture.sv
hdl/pmod_hygro_i2c.sv
sim/hdc1080_model.sv
sim/tb_pmod_hygro.sv

// ==== Bender.yml ====
package:
  name: pmod_hygro_i2c

sources:
  - hdl/hygro_pkg.sv
  - hdl/i2c_bit_phase.sv
  - hdl/hygro_sequencer.sv
  - hdl/hygro_data_capture.sv
  - hdl/pmod_hygro_i2c.sv
  - target: simulation
    files:
      - sim/hdc1080_model.sv
      - sim/tb_pmod_hygro.sv
